// File: include/sa_config.svh
//////////////////////////////////////////////////
// matmul tile configuration
// sizes, widths and byte order of one 8x8 tile
//////////////////////////////////////////////////
`ifndef SA_CONFIG_SVH
`define SA_CONFIG_SVH

// tile rows and columns
`define SA_SIDE 8

// signed operand width, int8
`define SA_ELEM_BITS 8

// dma word width
`define SA_WORD_BITS 32

// accumulator width
// 8 products of 16 bits need 19 bits signed
`define SA_ACC_BITS 19

// word address width for both buffers
`define SA_BUF_AW 6

// byte order of packed words
// 1 puts lane 0 in the low byte, 0 mirrors the lanes
`define SA_LITTLE_ENDIAN 1

`endif

// File: verilog/sa_data_pkg.sv
//////////////////////////////////////////////////
// datapath types and derived sizes of the tile
//////////////////////////////////////////////////
`default_nettype none

`include "sa_config.svh"

package sa_data_pkg;

  // operand, one matrix element
  typedef logic signed [`SA_ELEM_BITS-1:0] elem_t;
  // packed dma word
  typedef logic [`SA_WORD_BITS-1:0] word_t;
  // per-cell accumulator
  typedef logic signed [`SA_ACC_BITS-1:0] acc_t;
  // element index, one past the last for counters
  typedef logic [$clog2(`SA_SIDE*`SA_SIDE+1)-1:0] elem_idx_t;
  // buffer word address
  typedef logic [`SA_BUF_AW-1:0] buf_addr_t;

  // four int8 lanes per word
  localparam int ELEMS_PER_WORD   = `SA_WORD_BITS / `SA_ELEM_BITS;
  localparam int WORDS_PER_MATRIX = (`SA_SIDE * `SA_SIDE) / ELEMS_PER_WORD;
  // a first, b right behind it
  localparam int A_BASE_WORD      = 0;
  localparam int B_BASE_WORD      = A_BASE_WORD + WORDS_PER_MATRIX;

endpackage

`default_nettype wire

// File: verilog/sa_ctrl_pkg.sv
//////////////////////////////////////////////////
// sequencer phase and dma command encodings
//////////////////////////////////////////////////
`default_nettype none

package sa_ctrl_pkg;

  // sequencer phases
  typedef enum logic [2:0] {
    st_idle      = 3'd0,
    st_data_load = 3'd1,
    st_unpack_a  = 3'd2,
    st_unpack_b  = 3'd3,
    st_matmul    = 3'd4,
    st_store     = 3'd5,
    st_out       = 3'd6
  } seq_state_t;

  // start_rd_wr codes seen by the dma engines
  // a code other than none lasts one cycle
  typedef enum logic [1:0] {
    cmd_none  = 2'b00,
    cmd_read  = 2'b10,
    cmd_write = 2'b11
  } dma_cmd_t;

endpackage

`default_nettype wire

// File: verilog/sa_word_ram.sv
//////////////////////////////////////////////////
// word buffer, one write port and one registered read
//////////////////////////////////////////////////
`default_nettype none

module sa_word_ram
  import sa_data_pkg::*;
#(
  parameter int  DEPTH  = 32,
  parameter type data_t = word_t
) (
  input  wire logic      clk,
  input  wire logic      we,
  input  wire buf_addr_t waddr,
  input  wire data_t     wdata,
  input  wire buf_addr_t raddr,
  output data_t          rdata
);

  // address bits actually decoded
  localparam int AW = $clog2(DEPTH);

  data_t mem [DEPTH];

  // write side
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr[AW-1:0]] <= wdata;
    end
  end

  // read data one cycle after the address
  always_ff @(posedge clk) begin
    rdata <= mem[raddr[AW-1:0]];
  end

endmodule

`default_nettype wire

// File: verilog/sa_operand_regs.sv
//////////////////////////////////////////////////
// operand unpack, buffered words into a rows and b columns
//////////////////////////////////////////////////
`default_nettype none

`include "sa_config.svh"

module sa_operand_regs
  import sa_data_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rstn,
  input  wire logic  unpack_a,
  input  wire logic  unpack_b,
  output buf_addr_t  raddr,
  input  wire word_t rdata,
  output logic       a_done,
  output logic       b_done,
  output elem_t      a_row [`SA_SIDE][`SA_SIDE],
  output elem_t      b_col [`SA_SIDE][`SA_SIDE]
);

  localparam int ELEMS  = `SA_SIDE * `SA_SIDE;
  localparam int LANE_W = $clog2(ELEMS_PER_WORD);

  elem_idx_t         k;
  elem_idx_t         k_d;
  logic [LANE_W-1:0] lane_raw;
  logic [LANE_W-1:0] lane;
  elem_t             lane_byte;
  logic              wr_en;

  //////////////////////////////////////////////////
  // element counter
  //////////////////////////////////////////////////

  // k issues the read, k_d follows the data
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      k   <= '0;
      k_d <= '0;
    end else begin
      k_d <= k;
      if (a_done || b_done) begin
        k <= '0;
      end else if (unpack_a || unpack_b) begin
        k <= k + 1'b1;
      end else begin
        k <= '0;
      end
    end
  end

  // element 63 lands in the last cycle of the phase
  assign a_done = unpack_a && (k == elem_idx_t'(ELEMS));
  assign b_done = unpack_b && (k == elem_idx_t'(ELEMS));

  // base plus k/4
  assign raddr = buf_addr_t'((unpack_b ? B_BASE_WORD : A_BASE_WORD) + k / ELEMS_PER_WORD);

  //////////////////////////////////////////////////
  // lane pick and register write
  //////////////////////////////////////////////////

  // lane order flips for big-endian words
  always_comb begin
    lane_raw = LANE_W'(k_d % ELEMS_PER_WORD);
    if (`SA_LITTLE_ENDIAN != 0) begin
      lane = lane_raw;
    end else begin
      lane = LANE_W'(ELEMS_PER_WORD - 1) - lane_raw;
    end
  end

  assign lane_byte = elem_t'(rdata[lane*`SA_ELEM_BITS +: `SA_ELEM_BITS]);

  // nothing pending in the first cycle of a phase
  assign wr_en = (unpack_a || unpack_b) && (k != '0);

  always_ff @(posedge clk) begin
    // a row-major, row k/8 column k%8
    if (wr_en && unpack_a) begin
      a_row[k_d / `SA_SIDE][k_d % `SA_SIDE] <= lane_byte;
    end
    // b transposed, column k%8 position k/8
    if (wr_en && unpack_b) begin
      b_col[k_d % `SA_SIDE][k_d / `SA_SIDE] <= lane_byte;
    end
  end

endmodule

`default_nettype wire

// File: verilog/sa_pe_array.sv
//////////////////////////////////////////////////
// output-stationary systolic grid
// skewed operand feed, mac cells and result readout
//////////////////////////////////////////////////
`default_nettype none

`include "sa_config.svh"

module sa_pe_array
  import sa_data_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rstn,
  input  wire logic      run,
  input  wire elem_t     a_row [`SA_SIDE][`SA_SIDE],
  input  wire elem_t     b_col [`SA_SIDE][`SA_SIDE],
  input  wire elem_idx_t rd_idx,
  output acc_t           acc,
  output logic           mm_done
);

  // last operand pair reaches cell 7,7 at step 3*side-3
  localparam int STEPS  = 3 * `SA_SIDE - 2;
  localparam int STEP_W = $clog2(STEPS);

  logic              busy;
  logic              active;
  logic [STEP_W-1:0] step;
  elem_t             a_feed [`SA_SIDE];
  elem_t             b_feed [`SA_SIDE];
  elem_t             a_q    [`SA_SIDE][`SA_SIDE];
  elem_t             b_q    [`SA_SIDE][`SA_SIDE];
  acc_t              acc_q  [`SA_SIDE][`SA_SIDE];

  //////////////////////////////////////////////////
  // run-cycle counter
  //////////////////////////////////////////////////

  // step 0 is the run cycle itself
  assign active  = run || busy;
  assign mm_done = active && (step == STEP_W'(STEPS - 1));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy <= 1'b0;
      step <= '0;
    end else if (mm_done) begin
      busy <= 1'b0;
      step <= '0;
    end else if (active) begin
      busy <= 1'b1;
      step <= step + 1'b1;
    end
  end

  // skew, row i and column j start i and j steps late
  // zeros outside the window keep the pipes flushed
  always_comb begin
    for (int i = 0; i < `SA_SIDE; i++) begin
      a_feed[i] = '0;
      b_feed[i] = '0;
      if (active && (int'(step) >= i) && (int'(step) - i < `SA_SIDE)) begin
        a_feed[i] = a_row[i][int'(step) - i];
        b_feed[i] = b_col[i][int'(step) - i];
      end
    end
  end

  //////////////////////////////////////////////////
  // cell grid
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `SA_SIDE; i++) begin : g_row
    for (genvar j = 0; j < `SA_SIDE; j++) begin : g_col
      elem_t                             a_in;
      elem_t                             b_in;
      logic signed [2*`SA_ELEM_BITS-1:0] prod;

      // a moves right, b moves down
      if (j == 0) begin : g_a_edge
        assign a_in = a_feed[i];
      end else begin : g_a_pass
        assign a_in = a_q[i][j-1];
      end
      if (i == 0) begin : g_b_edge
        assign b_in = b_feed[j];
      end else begin : g_b_pass
        assign b_in = b_q[i-1][j];
      end

      assign prod = a_in * b_in;

      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          a_q[i][j] <= '0;
          b_q[i][j] <= '0;
        end else begin
          a_q[i][j] <= a_in;
          b_q[i][j] <= b_in;
        end
      end

      // run restarts the sum with the first product
      always_ff @(posedge clk) begin
        if (run) begin
          acc_q[i][j] <= acc_t'(prod);
        end else if (busy) begin
          acc_q[i][j] <= acc_q[i][j] + acc_t'(prod);
        end
      end
    end
  end

  // row rd_idx/8, column rd_idx%8
  assign acc = acc_q[rd_idx / `SA_SIDE][rd_idx % `SA_SIDE];

endmodule

`default_nettype wire

// File: verilog/sa_seq.sv
//////////////////////////////////////////////////
// phase sequencer
// dma commands, word count, store index and done
//////////////////////////////////////////////////
`default_nettype none

`include "sa_config.svh"

module sa_seq
  import sa_data_pkg::*;
  import sa_ctrl_pkg::*;
(
  input  wire logic clk,
  input  wire logic rstn,
  input  wire logic start,
  input  wire logic read_data_vld,
  input  wire logic wr_pull,
  input  wire logic wr_done,
  output dma_cmd_t  start_rd_wr,
  output buf_addr_t dma_cnt,
  output logic      done,
  output logic      in_we,
  output logic      unpack_a,
  output logic      unpack_b,
  input  wire logic a_done,
  input  wire logic b_done,
  output logic      run,
  input  wire logic mm_done,
  output elem_idx_t rd_idx,
  output logic      out_we,
  output buf_addr_t out_waddr
);

  // a and b words per load
  localparam int LOAD_WORDS = 2 * WORDS_PER_MATRIX;
  localparam int ELEMS      = `SA_SIDE * `SA_SIDE;

  seq_state_t state;
  logic       load_last;
  logic       store_last;

  // load closes once the count reaches 32
  assign load_last  = (state == st_data_load) && (dma_cnt == buf_addr_t'(LOAD_WORDS));
  assign store_last = (state == st_store) && (rd_idx == elem_idx_t'(ELEMS - 1));

  // dma_cnt is the input buffer write address
  assign in_we    = (state == st_data_load) && read_data_vld && !load_last;
  assign unpack_a = (state == st_unpack_a);
  assign unpack_b = (state == st_unpack_b);
  // store index doubles as output word address
  assign out_waddr = buf_addr_t'(rd_idx);

  //////////////////////////////////////////////////
  // phase register and counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state       <= st_idle;
      start_rd_wr <= cmd_none;
      dma_cnt     <= '0;
      done        <= 1'b0;
      run         <= 1'b0;
      rd_idx      <= '0;
      out_we      <= 1'b0;
    end else begin
      // strobes last a single cycle
      start_rd_wr <= cmd_none;
      done        <= 1'b0;
      run         <= 1'b0;
      case (state)
        st_idle: begin
          dma_cnt <= '0;
          rd_idx  <= '0;
          if (start) begin
            start_rd_wr <= cmd_read;
            state       <= st_data_load;
          end
        end
        st_data_load: begin
          // gaps in read_data_vld hold the count
          if (load_last) begin
            dma_cnt <= '0;
            state   <= st_unpack_a;
          end else if (read_data_vld) begin
            dma_cnt <= dma_cnt + 1'b1;
          end
        end
        st_unpack_a: begin
          if (a_done) begin
            state <= st_unpack_b;
          end
        end
        st_unpack_b: begin
          if (b_done) begin
            run   <= 1'b1;
            state <= st_matmul;
          end
        end
        st_matmul: begin
          if (mm_done) begin
            rd_idx <= '0;
            out_we <= 1'b1;
            state  <= st_store;
          end
        end
        st_store: begin
          // one result word per cycle
          if (store_last) begin
            rd_idx      <= '0;
            out_we      <= 1'b0;
            start_rd_wr <= cmd_write;
            state       <= st_out;
          end else begin
            rd_idx <= rd_idx + 1'b1;
          end
        end
        st_out: begin
          if (wr_done) begin
            dma_cnt <= '0;
            done    <= 1'b1;
            state   <= st_idle;
          end else if (wr_pull) begin
            dma_cnt <= dma_cnt + 1'b1;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/sa_core.sv
//////////////////////////////////////////////////
// 8x8 int8 matmul tile between dma reader and writer
//////////////////////////////////////////////////
`default_nettype none

`include "sa_config.svh"

module sa_core
  import sa_data_pkg::*;
  import sa_ctrl_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rstn,
  input  wire logic  start,
  input  wire logic  read_data_vld,
  input  wire word_t data_in,
  // load ends on the word count, rd_done is not needed
  input  wire logic  rd_done,
  input  wire logic  wr_pull,
  input  wire logic  wr_done,
  output dma_cmd_t   start_rd_wr,
  output buf_addr_t  dma_cnt,
  output word_t      data_out,
  output logic       done
);

  logic      in_we;
  buf_addr_t in_raddr;
  word_t     in_rdata;
  logic      unpack_a;
  logic      unpack_b;
  logic      a_done;
  logic      b_done;
  elem_t     a_row [`SA_SIDE][`SA_SIDE];
  elem_t     b_col [`SA_SIDE][`SA_SIDE];
  logic      run;
  logic      mm_done;
  elem_idx_t rd_idx;
  acc_t      acc;
  logic      out_we;
  buf_addr_t out_waddr;
  word_t     out_wdata;

  // results stored sign-extended to a full word
  assign out_wdata = {{(`SA_WORD_BITS - `SA_ACC_BITS){acc[`SA_ACC_BITS-1]}}, acc};

  sa_seq u_seq (
    .clk           (clk),
    .rstn          (rstn),
    .start         (start),
    .read_data_vld (read_data_vld),
    .wr_pull       (wr_pull),
    .wr_done       (wr_done),
    .start_rd_wr   (start_rd_wr),
    .dma_cnt       (dma_cnt),
    .done          (done),
    .in_we         (in_we),
    .unpack_a      (unpack_a),
    .unpack_b      (unpack_b),
    .a_done        (a_done),
    .b_done        (b_done),
    .run           (run),
    .mm_done       (mm_done),
    .rd_idx        (rd_idx),
    .out_we        (out_we),
    .out_waddr     (out_waddr)
  );

  // input words, a then b
  sa_word_ram #(
    .DEPTH  (2 * WORDS_PER_MATRIX),
    .data_t (word_t)
  ) u_in_buf (
    .clk   (clk),
    .we    (in_we),
    .waddr (dma_cnt),
    .wdata (data_in),
    .raddr (in_raddr),
    .rdata (in_rdata)
  );

  sa_operand_regs u_operand_regs (
    .clk      (clk),
    .rstn     (rstn),
    .unpack_a (unpack_a),
    .unpack_b (unpack_b),
    .raddr    (in_raddr),
    .rdata    (in_rdata),
    .a_done   (a_done),
    .b_done   (b_done),
    .a_row    (a_row),
    .b_col    (b_col)
  );

  sa_pe_array u_pe_array (
    .clk     (clk),
    .rstn    (rstn),
    .run     (run),
    .a_row   (a_row),
    .b_col   (b_col),
    .rd_idx  (rd_idx),
    .acc     (acc),
    .mm_done (mm_done)
  );

  // one result word per element, read back at dma_cnt
  sa_word_ram #(
    .DEPTH  (`SA_SIDE * `SA_SIDE),
    .data_t (word_t)
  ) u_out_buf (
    .clk   (clk),
    .we    (out_we),
    .waddr (out_waddr),
    .wdata (out_wdata),
    .raddr (dma_cnt),
    .rdata (data_out)
  );

endmodule

`default_nettype wire

// File: verification/sa_core_assertions.sv
//////////////////////////////////////////////////
// dma protocol assertions bound to the tile top
//////////////////////////////////////////////////
`default_nettype none

module sa_core_assertions
  import sa_data_pkg::*;
  import sa_ctrl_pkg::*;
(
  input wire logic      clk,
  input wire logic      rstn,
  input wire dma_cmd_t  start_rd_wr,
  input wire buf_addr_t dma_cnt,
  input wire logic      done
);

  localparam int LOAD_WORDS = 2 * WORDS_PER_MATRIX;

  // count of failed checks
  int unsigned fail_cnt = 0;
  logic        in_load;
  logic        in_out;

  // phase flags rebuilt from the dma commands
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      in_load <= 1'b0;
      in_out  <= 1'b0;
    end else begin
      if (start_rd_wr == cmd_read) begin
        in_load <= 1'b1;
      end else if (in_load && (dma_cnt == buf_addr_t'(LOAD_WORDS))) begin
        in_load <= 1'b0;
      end
      if (start_rd_wr == cmd_write) begin
        in_out <= 1'b1;
      end else if (done) begin
        in_out <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // strobes
  //////////////////////////////////////////////////

  a_read_strobe: assert property (@(posedge clk) disable iff (!rstn)
    (start_rd_wr == cmd_read) |=> (start_rd_wr == cmd_none))
    else begin
      fail_cnt++;
      $error("read command held longer than one cycle");
    end

  a_write_strobe: assert property (@(posedge clk) disable iff (!rstn)
    (start_rd_wr == cmd_write) |=> (start_rd_wr == cmd_none))
    else begin
      fail_cnt++;
      $error("write command held longer than one cycle");
    end

  a_done_strobe: assert property (@(posedge clk) disable iff (!rstn)
    done |=> !done)
    else begin
      fail_cnt++;
      $error("done held longer than one cycle");
    end

  //////////////////////////////////////////////////
  // word counter range
  //////////////////////////////////////////////////

  // load never goes past a and b
  a_load_range: assert property (@(posedge clk) disable iff (!rstn)
    in_load |-> (dma_cnt <= buf_addr_t'(LOAD_WORDS)))
    else begin
      fail_cnt++;
      $error("dma_cnt ran past the last load word");
    end

  // streaming holds or steps by one, wrapping after word 63
  a_out_step: assert property (@(posedge clk) disable iff (!rstn)
    in_out |=> ((dma_cnt == $past(dma_cnt)) ||
                (dma_cnt == buf_addr_t'($past(dma_cnt) + 1'b1))))
    else begin
      fail_cnt++;
      $error("dma_cnt skipped a word while streaming");
    end

endmodule

bind sa_core sa_core_assertions u_assertions (
  .clk         (clk),
  .rstn        (rstn),
  .start_rd_wr (start_rd_wr),
  .dma_cnt     (dma_cnt),
  .done        (done)
);

`default_nettype wire

// File: verification/sa_core_tb.sv
//////////////////////////////////////////////////
// testbench for the matmul tile
// dma read and write models, reference product
//////////////////////////////////////////////////
`default_nettype none

`include "sa_config.svh"

module sa_core_tb
  import sa_data_pkg::*;
  import sa_ctrl_pkg::*;
();

  localparam int SIDE           = `SA_SIDE;
  localparam int ELEMS          = SIDE * SIDE;
  localparam int LOAD_WORDS     = 2 * WORDS_PER_MATRIX;
  localparam int RESET_CYCLES   = 8;
  // a run takes about 400 cycles with random gaps
  localparam int RUNS           = 4;
  localparam int RUN_CYCLES     = 600;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + RUNS * RUN_CYCLES;
  localparam int unsigned SEED  = 32'hda73edde;

  logic      clk;
  logic      rstn;
  logic      start;
  logic      read_data_vld;
  word_t     data_in;
  logic      rd_done;
  logic      wr_pull;
  logic      wr_done;
  dma_cmd_t  start_rd_wr;
  buf_addr_t dma_cnt;
  word_t     data_out;
  logic      done;

  int    cycles = 0;
  elem_t a_mat [SIDE][SIDE];
  elem_t b_mat [SIDE][SIDE];
  word_t load_words [LOAD_WORDS];
  word_t exp_out [ELEMS];

  sa_core u_dut (
    .clk           (clk),
    .rstn          (rstn),
    .start         (start),
    .read_data_vld (read_data_vld),
    .data_in       (data_in),
    .rd_done       (rd_done),
    .wr_pull       (wr_pull),
    .wr_done       (wr_done),
    .start_rd_wr   (start_rd_wr),
    .dma_cnt       (dma_cnt),
    .data_out      (data_out),
    .done          (done)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // failure reporting and watchdogs
  //////////////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string sig, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else abort_run($sformatf("mismatch %s got 0x%h expected 0x%h", sig, got, exp));
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout, run still busy after %0d cycles", cycles));
    end
  end

  // protocol checks bound inside the dut
  always @(negedge clk) begin
    if (u_dut.u_assertions.fail_cnt != 0) begin
      abort_run("protocol assertion failed inside sa_core");
    end
  end

  //////////////////////////////////////////////////
  // operands and reference
  //////////////////////////////////////////////////

  // random bytes or all -128 for the accumulator extreme
  task automatic fill_operands(input bit extreme);
    for (int r = 0; r < SIDE; r++) begin
      for (int c = 0; c < SIDE; c++) begin
        a_mat[r][c] = extreme ? elem_t'(8'h80) : elem_t'($urandom);
        b_mat[r][c] = extreme ? elem_t'(8'h80) : elem_t'($urandom);
      end
    end
  endtask

  // four row-major lanes per word with a before b
  task automatic pack_words();
    int lane;
    for (int k = 0; k < ELEMS; k++) begin
      lane = k % ELEMS_PER_WORD;
      if (`SA_LITTLE_ENDIAN == 0) begin
        lane = ELEMS_PER_WORD - 1 - lane;
      end
      load_words[A_BASE_WORD + k / ELEMS_PER_WORD][lane*8 +: 8] = a_mat[k / SIDE][k % SIDE];
      load_words[B_BASE_WORD + k / ELEMS_PER_WORD][lane*8 +: 8] = b_mat[k / SIDE][k % SIDE];
    end
  endtask

  // one sign-extended word per element of a times b
  task automatic compute_reference();
    int sum;
    for (int r = 0; r < SIDE; r++) begin
      for (int c = 0; c < SIDE; c++) begin
        sum = 0;
        for (int k = 0; k < SIDE; k++) begin
          sum += int'(a_mat[r][k]) * int'(b_mat[k][c]);
        end
        exp_out[r*SIDE + c] = word_t'(sum);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // one tile from load to done
  //////////////////////////////////////////////////

  task automatic run_tile(input bit extreme);
    int        accepted;
    bit        vld;
    int        exp_cnt;
    int        pulls;
    bit        pull;
    bit        pending;
    buf_addr_t prev_cnt;
    fill_operands(extreme);
    pack_words();
    compute_reference();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_value("start_rd_wr", start_rd_wr, cmd_read);
    // read model presents words with random gaps
    // and may offer one surplus word after the last
    accepted = 0;
    vld      = 1'b0;
    while (accepted < LOAD_WORDS) begin
      @(posedge clk);
      if (vld) begin
        accepted++;
      end
      vld = ($urandom % 3 != 0);
      read_data_vld <= vld;
      if (vld && (accepted < LOAD_WORDS)) begin
        data_in <= load_words[accepted];
      end else if (vld) begin
        data_in <= ~load_words[A_BASE_WORD];
      end
      @(negedge clk);
      check_value("start_rd_wr", start_rd_wr, cmd_none);
      check_value("dma_cnt", dma_cnt, accepted);
    end
    // surplus word dropped, count back to 0
    @(posedge clk);
    read_data_vld <= 1'b0;
    rd_done       <= 1'b1;
    @(negedge clk);
    check_value("dma_cnt", dma_cnt, 0);
    @(posedge clk);
    rd_done <= 1'b0;
    // unpack, matmul and store run on their own
    do begin
      @(negedge clk);
      check_value("done", done, 0);
    end while (start_rd_wr != cmd_write);
    // write model with data_out one cycle behind the address
    check_value("dma_cnt", dma_cnt, 0);
    exp_cnt  = 0;
    pulls    = 0;
    pending  = 1'b0;
    prev_cnt = dma_cnt;
    do begin
      @(posedge clk);
      exp_cnt += pending;
      pull = (pulls < ELEMS) && ($urandom % 3 != 0);
      wr_pull <= pull;
      pending = pull;
      pulls += pull;
      @(negedge clk);
      check_value("start_rd_wr", start_rd_wr, cmd_none);
      check_value("dma_cnt", dma_cnt, buf_addr_t'(exp_cnt));
      check_value($sformatf("data_out[%0d]", prev_cnt), data_out, exp_out[prev_cnt]);
      prev_cnt = dma_cnt;
    end while ((pulls < ELEMS) || pending);
    @(posedge clk);
    wr_done <= 1'b1;
    @(posedge clk);
    wr_done <= 1'b0;
    @(negedge clk);
    check_value("done", done, 1);
    @(negedge clk);
    check_value("done", done, 0);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    clk           = 1'b0;
    rstn          = 1'b0;
    start         = 1'b0;
    read_data_vld = 1'b0;
    data_in       = '0;
    rd_done       = 1'b0;
    wr_pull       = 1'b0;
    wr_done       = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check_value("start_rd_wr", start_rd_wr, cmd_none);
    check_value("dma_cnt", dma_cnt, 0);
    check_value("done", done, 0);
    // back to back tiles with new data each time
    run_tile(1'b0);
    run_tile(1'b0);
    run_tile(1'b1);
    run_tile(1'b0);
    if (u_dut.u_assertions.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      abort_run("protocol assertion failed inside sa_core");
    end
  end

endmodule

`default_nettype wire

// File: sa_core.f
+incdir+include
verilog/sa_data_pkg.sv
verilog/sa_ctrl_pkg.sv
verilog/sa_word_ram.sv
verilog/sa_operand_regs.sv
verilog/sa_pe_array.sv
verilog/sa_seq.sv
verilog/sa_core.sv
verification/sa_core_assertions.sv
verification/sa_core_tb.sv

// File: Bender.yml
package:
  name: sa_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/sa_data_pkg.sv
      - verilog/sa_ctrl_pkg.sv
      - verilog/sa_word_ram.sv
      - verilog/sa_operand_regs.sv
      - verilog/sa_pe_array.sv
      - verilog/sa_seq.sv
      - verilog/sa_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/sa_core_assertions.sv
      - verification/sa_core_tb.sv
